// ==== frame_geom_pkg.sv ====
`default_nettype none

// geometry of the event frames and of the class-result memory
package frame_geom_pkg;

    // sensor frame, loaded in raster order
    localparam int x_length = 320;
    localparam int y_depth = 240;
    localparam int frame_pixels = x_length * y_depth;

    // chip-side index widths
    localparam int col_width = 9;
    localparam int row_width = 8;

    // linear pixel address, row * x_length + col
    localparam int pix_addr_width = 17;

    // class results, region * 20 + byte index
    localparam int class_addr_width = 11;
    localparam int class_depth = 1 << class_addr_width;

endpackage

`default_nettype wire

// ==== chip_cmd_pkg.sv ====
`default_nettype none

// serial configuration frames and the readout command set of the chip
package chip_cmd_pkg;

    // frame is {data, addr}, shifted out lsb first
    localparam int cfg_data_width = 16;
    localparam int cfg_addr_width = 7;
    localparam int cfg_frame_len = cfg_data_width + cfg_addr_width;

    // counter for the 16 inbound readback bits
    localparam int cfg_cnt_width = 4;

    // every sequencer command targets this register
    localparam logic [cfg_addr_width-1:0] readout_reg = 7'd58;

    // readout per region
    localparam int class_bytes = 20;
    localparam int settle_cycles = 27;
    localparam int seq_cnt_width = 5;

    // data words written to readout_reg
    // class reads carry the byte index in the low bits
    typedef enum logic [cfg_data_width-1:0] {
        cmd_class_rd = 16'h0000,
        cmd_run      = 16'h8000
    } chip_cmd_e;

endpackage

`default_nettype wire

// ==== frame_loader.sv ====
`default_nettype none

module frame_loader (
    input  logic clk,
    input  logic reset,
    input  logic pix_wr,
    input  logic pix_pos,
    input  logic pix_neg,
    input  logic [frame_geom_pkg::row_width-1:0] chip_row,
    input  logic [frame_geom_pkg::col_width-1:0] chip_col,
    output logic data_in_pos,
    output logic data_in_neg
);
    import frame_geom_pkg::*;

    logic [col_width-1:0] wr_col;
    logic [row_width-1:0] wr_row;
    logic [pix_addr_width-1:0] wr_addr;
    logic [pix_addr_width-1:0] rd_addr;

    // one-bit event frames
    logic mem_pos [frame_pixels];
    logic mem_neg [frame_pixels];

    ////////////////////////////////////////////////////////////
    // host write side
    ////////////////////////////////////////////////////////////

    assign wr_addr = pix_addr_width'(wr_row * x_length + wr_col);

    // raster counters, frozen once the last row is done
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_col <= '0;
            wr_row <= '0;
        end else if (pix_wr && wr_row < y_depth) begin
            if (wr_col < x_length - 1) begin
                wr_col <= wr_col + 1'b1;
            end else begin
                wr_col <= '0;
                wr_row <= wr_row + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_wr && wr_row < y_depth) begin
            mem_pos[wr_addr] <= pix_pos;
            mem_neg[wr_addr] <= pix_neg;
        end
    end

    ////////////////////////////////////////////////////////////
    // chip read side
    ////////////////////////////////////////////////////////////

    assign rd_addr = pix_addr_width'(chip_row * x_length + chip_col);

    // registered read, pixel shows one cycle after its address
    always_ff @(posedge clk) begin
        data_in_pos <= mem_pos[rd_addr];
        data_in_neg <= mem_neg[rd_addr];
    end

endmodule

`default_nettype wire

// ==== spi_config_port.sv ====
`default_nettype none

module spi_config_port (
    input  logic clk,
    input  logic reset,
    input  logic cmd_load,
    input  logic cmd_rd,
    input  logic [chip_cmd_pkg::cfg_addr_width-1:0] cmd_addr,
    input  logic [chip_cmd_pkg::cfg_data_width-1:0] cmd_data,
    output logic spi_din,
    output logic spi_update,
    output logic spi_capture,
    input  logic spi_out,
    output logic frame_done,
    output logic [chip_cmd_pkg::cfg_data_width-1:0] rd_data,
    output logic rd_valid
);
    import chip_cmd_pkg::*;

    logic [cfg_frame_len-1:0] out_sh;
    // one-hot, reaches bit 0 in cycle 24 after the load
    logic [cfg_frame_len:0] strobe_sh;
    logic strobe_rd;
    logic [cfg_data_width-1:0] in_sh;
    logic [cfg_cnt_width-1:0] in_cnt;
    logic in_busy;

    ////////////////////////////////////////////////////////////
    // outbound frame
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_sh <= '0;
            strobe_sh <= '0;
            strobe_rd <= 1'b0;
        end else if (cmd_load) begin
            // read frames send the address with a zero data field
            out_sh <= cmd_rd ? {cfg_data_width'(0), cmd_addr} : {cmd_data, cmd_addr};
            strobe_sh <= {1'b1, cfg_frame_len'(0)};
            strobe_rd <= cmd_rd;
        end else begin
            out_sh <= out_sh >> 1;
            strobe_sh <= strobe_sh >> 1;
        end
    end

    // bit 0 appears in the cycle after the load
    assign spi_din = out_sh[0];
    assign spi_update = strobe_sh[0] & ~strobe_rd;
    assign spi_capture = strobe_sh[0] & strobe_rd;

    ////////////////////////////////////////////////////////////
    // inbound readback
    ////////////////////////////////////////////////////////////

    // 16 samples, from the capture cycle through cycle 39
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_busy <= 1'b0;
            in_cnt <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            if (spi_capture) begin
                in_busy <= 1'b1;
                in_cnt <= cfg_cnt_width'(1);
            end else if (in_busy) begin
                if (in_cnt == cfg_cnt_width'(cfg_data_width - 1)) begin
                    // last sample, word is complete in cycle 40
                    in_busy <= 1'b0;
                    in_cnt <= '0;
                    rd_valid <= 1'b1;
                end else begin
                    in_cnt <= in_cnt + 1'b1;
                end
            end
        end
    end

    // shift in at the top, first sample ends up in bit 0
    always_ff @(posedge clk) begin
        if (spi_capture || in_busy) begin
            in_sh <= {spi_out, in_sh[cfg_data_width-1:1]};
        end
    end

    assign rd_data = in_sh;

    // one credit back per finished frame
    assign frame_done = spi_update | rd_valid;

endmodule

`default_nettype wire

// ==== spi_cmd_arbiter.sv ====
`default_nettype none

module spi_cmd_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic seq_cmd_valid,
    input  logic [chip_cmd_pkg::cfg_data_width-1:0] seq_cmd_data,
    output logic seq_cmd_accept,
    input  logic host_cmd_valid,
    input  logic host_cmd_rd,
    input  logic [chip_cmd_pkg::cfg_addr_width-1:0] host_cmd_addr,
    input  logic [chip_cmd_pkg::cfg_data_width-1:0] host_cmd_data,
    output logic host_cmd_accept,
    input  logic frame_done,
    output logic cmd_load,
    output logic cmd_rd,
    output logic [chip_cmd_pkg::cfg_addr_width-1:0] cmd_addr,
    output logic [chip_cmd_pkg::cfg_data_width-1:0] cmd_data
);
    import chip_cmd_pkg::*;

    // the port takes one frame at a time
    logic credit;
    logic issue;

    assign issue = credit & (seq_cmd_valid | host_cmd_valid);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit <= 1'b1;
            cmd_load <= 1'b0;
            seq_cmd_accept <= 1'b0;
            host_cmd_accept <= 1'b0;
        end else begin
            cmd_load <= issue;
            // sequencer wins a tie
            seq_cmd_accept <= issue & seq_cmd_valid;
            host_cmd_accept <= issue & ~seq_cmd_valid;
            if (issue) begin
                credit <= 1'b0;
            end else if (frame_done) begin
                credit <= 1'b1;
            end
        end
    end

    // command fields, valid with cmd_load
    always_ff @(posedge clk) begin
        if (issue) begin
            if (seq_cmd_valid) begin
                // sequencer only ever writes the readout register
                cmd_rd <= 1'b0;
                cmd_addr <= readout_reg;
                cmd_data <= seq_cmd_data;
            end else begin
                cmd_rd <= host_cmd_rd;
                cmd_addr <= host_cmd_addr;
                cmd_data <= host_cmd_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== class_readout_seq.sv ====
`default_nettype none

module class_readout_seq (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic cnn_ready,
    input  logic cnn_done,
    input  logic done,
    input  logic [7:0] parallel_out,
    output logic seq_cmd_valid,
    output logic [chip_cmd_pkg::cfg_data_width-1:0] seq_cmd_data,
    input  logic seq_cmd_accept,
    output logic class_wr,
    output logic [frame_geom_pkg::class_addr_width-1:0] class_addr,
    output logic [7:0] class_byte,
    output logic result_ready
);
    import frame_geom_pkg::*;
    import chip_cmd_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_wait_ready,
        s_wait_done,
        s_wait_result,
        s_issue_read,
        s_settle,
        s_finish
    } seq_state_e;

    seq_state_e state;
    logic last_region;
    logic [class_addr_width-1:0] region;
    logic [seq_cnt_width-1:0] byte_idx;
    logic [seq_cnt_width-1:0] wait_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= s_idle;
            last_region <= 1'b0;
            region <= '0;
            byte_idx <= '0;
            wait_cnt <= '0;
            seq_cmd_valid <= 1'b0;
            seq_cmd_data <= cmd_class_rd;
            class_wr <= 1'b0;
            class_addr <= '0;
            class_byte <= '0;
            result_ready <= 1'b0;
        end else begin
            class_wr <= 1'b0;
            result_ready <= 1'b0;
            // command held until the arbiter takes it
            if (seq_cmd_accept) begin
                seq_cmd_valid <= 1'b0;
            end
            case (state)
                s_idle: begin
                    if (start) begin
                        seq_cmd_valid <= 1'b1;
                        seq_cmd_data <= cmd_run;
                        region <= '0;
                        last_region <= 1'b0;
                        state <= s_wait_ready;
                    end
                end
                s_wait_ready: begin
                    if (cnn_ready) begin
                        seq_cmd_valid <= 1'b1;
                        seq_cmd_data <= cmd_run;
                        state <= s_wait_done;
                    end
                end
                s_wait_done: begin
                    if (done) begin
                        seq_cmd_valid <= 1'b1;
                        seq_cmd_data <= cmd_run;
                        state <= s_wait_result;
                    end
                end
                s_wait_result: begin
                    // cnn_done marks the last region
                    if (cnn_ready || cnn_done) begin
                        last_region <= cnn_done;
                        byte_idx <= '0;
                        state <= s_issue_read;
                    end
                end
                s_issue_read: begin
                    seq_cmd_valid <= 1'b1;
                    seq_cmd_data <= cmd_class_rd | cfg_data_width'(byte_idx);
                    wait_cnt <= '0;
                    state <= s_settle;
                end
                s_settle: begin
                    // count from the accept, sample 4 cycles past the update
                    if (!seq_cmd_valid) begin
                        if (wait_cnt == seq_cnt_width'(settle_cycles)) begin
                            class_wr <= 1'b1;
                            class_byte <= parallel_out;
                            class_addr <= class_addr_width'(region * class_bytes + byte_idx);
                            if (byte_idx == seq_cnt_width'(class_bytes - 1)) begin
                                state <= s_finish;
                            end else begin
                                byte_idx <= byte_idx + 1'b1;
                                state <= s_issue_read;
                            end
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                s_finish: begin
                    if (last_region) begin
                        result_ready <= 1'b1;
                        state <= s_idle;
                    end else begin
                        // step the chip to the next region
                        seq_cmd_valid <= 1'b1;
                        seq_cmd_data <= cmd_run;
                        region <= region + 1'b1;
                        state <= s_wait_done;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== class_mem.sv ====
`default_nettype none

module class_mem (
    input  logic clk,
    input  logic reset,
    input  logic class_wr,
    input  logic [frame_geom_pkg::class_addr_width-1:0] class_addr,
    input  logic [7:0] class_byte,
    input  logic class_rd,
    output logic [7:0] class_rd_data
);
    import frame_geom_pkg::*;

    logic [7:0] mem [class_depth];
    logic [class_addr_width-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (class_wr) begin
            mem[class_addr] <= class_byte;
        end
    end

    // host drain, pointer restarts whenever class_rd drops
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (class_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end else begin
            rd_ptr <= '0;
        end
    end

    // entry at the pointer, one cycle after each class_rd cycle
    always_ff @(posedge clk) begin
        if (class_rd) begin
            class_rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== cnn_harness_top.sv ====
`default_nettype none

module cnn_harness_top (
    input  logic clk,
    input  logic reset,
    // frame loading
    input  logic pix_wr,
    input  logic pix_pos,
    input  logic pix_neg,
    input  logic [frame_geom_pkg::row_width-1:0] chip_row,
    input  logic [frame_geom_pkg::col_width-1:0] chip_col,
    output logic data_in_pos,
    output logic data_in_neg,
    // host configuration commands
    input  logic host_cmd_valid,
    input  logic host_cmd_rd,
    input  logic [chip_cmd_pkg::cfg_addr_width-1:0] host_cmd_addr,
    input  logic [chip_cmd_pkg::cfg_data_width-1:0] host_cmd_data,
    output logic host_cmd_accept,
    output logic [chip_cmd_pkg::cfg_data_width-1:0] host_rd_data,
    output logic host_rd_valid,
    // serial pins of the chip
    output logic spi_din,
    output logic spi_update,
    output logic spi_capture,
    input  logic spi_out,
    // readout control
    input  logic start,
    input  logic cnn_ready,
    input  logic cnn_done,
    input  logic done,
    input  logic [7:0] parallel_out,
    output logic result_ready,
    // result drain
    input  logic class_rd,
    output logic [7:0] class_rd_data
);
    import frame_geom_pkg::*;
    import chip_cmd_pkg::*;

    // sequencer to arbiter
    logic seq_cmd_valid;
    logic [cfg_data_width-1:0] seq_cmd_data;
    logic seq_cmd_accept;

    // arbiter to serial port
    logic cmd_load;
    logic cmd_rd;
    logic [cfg_addr_width-1:0] cmd_addr;
    logic [cfg_data_width-1:0] cmd_data;
    logic frame_done;

    // sequencer to result memory
    logic class_wr;
    logic [class_addr_width-1:0] class_addr;
    logic [7:0] class_byte;

    frame_loader u_frame_loader (
        .clk(clk),
        .reset(reset),
        .pix_wr(pix_wr),
        .pix_pos(pix_pos),
        .pix_neg(pix_neg),
        .chip_row(chip_row),
        .chip_col(chip_col),
        .data_in_pos(data_in_pos),
        .data_in_neg(data_in_neg)
    );

    spi_cmd_arbiter u_arbiter (
        .clk(clk),
        .reset(reset),
        .seq_cmd_valid(seq_cmd_valid),
        .seq_cmd_data(seq_cmd_data),
        .seq_cmd_accept(seq_cmd_accept),
        .host_cmd_valid(host_cmd_valid),
        .host_cmd_rd(host_cmd_rd),
        .host_cmd_addr(host_cmd_addr),
        .host_cmd_data(host_cmd_data),
        .host_cmd_accept(host_cmd_accept),
        .frame_done(frame_done),
        .cmd_load(cmd_load),
        .cmd_rd(cmd_rd),
        .cmd_addr(cmd_addr),
        .cmd_data(cmd_data)
    );

    spi_config_port u_spi (
        .clk(clk),
        .reset(reset),
        .cmd_load(cmd_load),
        .cmd_rd(cmd_rd),
        .cmd_addr(cmd_addr),
        .cmd_data(cmd_data),
        .spi_din(spi_din),
        .spi_update(spi_update),
        .spi_capture(spi_capture),
        .spi_out(spi_out),
        .frame_done(frame_done),
        .rd_data(host_rd_data),
        .rd_valid(host_rd_valid)
    );

    class_readout_seq u_seq (
        .clk(clk),
        .reset(reset),
        .start(start),
        .cnn_ready(cnn_ready),
        .cnn_done(cnn_done),
        .done(done),
        .parallel_out(parallel_out),
        .seq_cmd_valid(seq_cmd_valid),
        .seq_cmd_data(seq_cmd_data),
        .seq_cmd_accept(seq_cmd_accept),
        .class_wr(class_wr),
        .class_addr(class_addr),
        .class_byte(class_byte),
        .result_ready(result_ready)
    );

    class_mem u_class_mem (
        .clk(clk),
        .reset(reset),
        .class_wr(class_wr),
        .class_addr(class_addr),
        .class_byte(class_byte),
        .class_rd(class_rd),
        .class_rd_data(class_rd_data)
    );

endmodule

`default_nettype wire

// ==== cnn_harness_assert.sv ====
`default_nettype none

module cnn_harness_assert (
    input logic clk,
    input logic reset,
    input logic cmd_load,
    input logic frame_done,
    input logic spi_update,
    input logic spi_capture,
    input logic result_ready
);

    // a frame is open from its load until its done pulse
    logic busy;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (cmd_load) begin
            busy <= 1'b1;
        end else if (frame_done) begin
            busy <= 1'b0;
        end
    end

    // update or capture lands in cycle 24 after the load, never elsewhere
    a_strobe_after_load: assert property (@(posedge clk) disable iff (reset)
        cmd_load |-> ##24 (spi_update || spi_capture))
        else $error("strobe did not follow cmd_load by 24 cycles");
    a_strobe_has_load: assert property (@(posedge clk) disable iff (reset)
        (spi_update || spi_capture) |-> $past(cmd_load, 24))
        else $error("strobe without a cmd_load 24 cycles earlier");

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        cmd_load |-> !busy)
        else $error("cmd_load while a frame is in progress");

    a_result_pulse: assert property (@(posedge clk) disable iff (reset)
        result_ready |=> !result_ready)
        else $error("result_ready held longer than one cycle");

endmodule

bind spi_config_port cnn_harness_assert u_spi_assert (
    .clk(clk),
    .reset(reset),
    .cmd_load(cmd_load),
    .frame_done(frame_done),
    .spi_update(spi_update),
    .spi_capture(spi_capture),
    .result_ready(1'b0)
);

bind class_readout_seq cnn_harness_assert u_seq_assert (
    .clk(clk),
    .reset(reset),
    .cmd_load(1'b0),
    .frame_done(1'b0),
    .spi_update(1'b0),
    .spi_capture(1'b0),
    .result_ready(result_ready)
);

`default_nettype wire

// ==== tb_cnn_harness.sv ====
`default_nettype none

module tb_cnn_harness;
    import frame_geom_pkg::*;
    import chip_cmd_pkg::*;

    localparam int clk_period = 8;
    localparam int n_pixels = 700;
    localparam int n_probes = 200;
    localparam int n_regions = 3;
    localparam int n_entries = n_regions * class_bytes;
    localparam logic [cfg_addr_width-1:0] host_wr_addr = 7'h15;
    localparam logic [cfg_addr_width-1:0] host_rd_addr = 7'h21;
    // start and ready runs, then a done run and 20 reads per region, a step run between regions
    localparam int seq_updates = 2 + n_regions * (1 + class_bytes) + (n_regions - 1);
    // worst case per region: read frames with settle, run frames with the longest chip delay
    localparam int region_cycles = class_bytes * (cfg_frame_len + settle_cycles + 10)
                                 + 3 * (cfg_frame_len + 20);
    localparam int worst_cycles = 2 * 60 + n_pixels + n_probes
                                + 2 * (n_regions * region_cycles + n_entries + 50);
    localparam int watchdog_time = (worst_cycles + 1000) * clk_period;

    // chip model event kinds
    localparam int ev_ready = 1;
    localparam int ev_done = 2;
    localparam int ev_result = 3;

    logic clk;
    logic reset;
    logic pix_wr, pix_pos, pix_neg;
    logic [row_width-1:0] chip_row;
    logic [col_width-1:0] chip_col;
    logic data_in_pos, data_in_neg;
    logic host_cmd_valid, host_cmd_rd;
    logic [cfg_addr_width-1:0] host_cmd_addr;
    logic [cfg_data_width-1:0] host_cmd_data;
    logic host_cmd_accept;
    logic [cfg_data_width-1:0] host_rd_data;
    logic host_rd_valid;
    logic spi_din, spi_update, spi_capture;
    logic spi_out = 1'b0;
    logic start;
    logic cnn_ready = 1'b0;
    logic cnn_done = 1'b0;
    logic done = 1'b0;
    logic [7:0] parallel_out = 8'h00;
    logic result_ready;
    logic class_rd;
    logic [7:0] class_rd_data;

    integer seed;
    int errors;
    int checks;

    cnn_harness_top uut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    function automatic logic [7:0] class_ref(input int region, input int index);
        class_ref = 8'((region * 37 + index * 11 + 5) % 256);
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("FAIL %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // chip model
    ////////////////////////////////////////////////////////////

    // last 23 bits seen on spi_din, complete in the update cycle
    logic [cfg_frame_len-1:0] din_sh = '0;
    logic [cfg_data_width-1:0] upd_data;
    logic [cfg_addr_width-1:0] upd_addr;
    assign {upd_data, upd_addr} = din_sh;

    always @(posedge clk) begin
        din_sh <= {spi_din, din_sh[cfg_frame_len-1:1]};
    end

    int upd_cnt = 0;
    int run_cnt = 0;
    int reads_seen = 0;
    int chip_region = 0;
    int pend_delay = 0;
    int pend_kind = 0;

    always @(posedge clk) begin
        cnn_ready <= 1'b0;
        done <= 1'b0;
        cnn_done <= 1'b0;
        if (start) begin
            run_cnt <= 0;
            reads_seen <= 0;
        end
        // random response delay after a run command
        if (pend_delay > 0) begin
            pend_delay <= pend_delay - 1;
            if (pend_delay == 1) begin
                if (pend_kind == ev_ready) begin
                    cnn_ready <= 1'b1;
                end else if (pend_kind == ev_done) begin
                    done <= 1'b1;
                end else if (chip_region == n_regions - 1) begin
                    cnn_done <= 1'b1;
                end else begin
                    cnn_ready <= 1'b1;
                end
            end
        end
        if (spi_update) begin
            upd_cnt <= upd_cnt + 1;
            if (upd_addr == readout_reg && upd_data == cmd_run) begin
                run_cnt <= run_cnt + 1;
                pend_delay <= 2 + ($random(seed) & 15);
                // first run asks for ready, then done and result alternate
                if (run_cnt == 0) begin
                    pend_kind <= ev_ready;
                end else if (run_cnt % 2 == 1) begin
                    pend_kind <= ev_done;
                end else begin
                    pend_kind <= ev_result;
                    chip_region <= (run_cnt - 2) / 2;
                end
            end else if (upd_addr == readout_reg && upd_data < class_bytes) begin
                reads_seen <= reads_seen + 1;
                parallel_out <= class_ref(chip_region, int'(upd_data));
            end
        end
    end

    // readback, bit 0 waits on spi_out until the capture samples it
    logic [cfg_data_width-1:0] rd_pattern;
    logic [cfg_data_width-1:0] rb_sh = '0;
    int rb_left = 0;

    always @(posedge clk) begin
        if (spi_capture || rb_left > 0) begin
            if (rb_left == 1) begin
                rb_left <= 0;
                rb_sh <= rd_pattern;
                spi_out <= rd_pattern[0];
            end else begin
                rb_left <= spi_capture ? cfg_data_width - 1 : rb_left - 1;
                rb_sh <= rb_sh >> 1;
                spi_out <= rb_sh[1];
            end
        end else begin
            rb_sh <= rd_pattern;
            spi_out <= rd_pattern[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////

    int cyc = 0;
    int host_load_cyc = 0;
    int host_wait_ends = 0;
    int host_wr_seen = 0;
    int drain_idx = 0;
    logic check_wait;
    logic [cfg_frame_len-1:0] exp_host_word;
    logic probe, exp_pos, exp_neg;
    logic probe_d = 1'b0;
    logic exp_pos_d, exp_neg_d;
    logic drain_d = 1'b0;
    logic pos_bits [n_pixels];
    logic neg_bits [n_pixels];

    always @(posedge clk) begin
        cyc <= cyc + 1;
        // frame ends seen while a host command waits
        if (!host_cmd_valid) begin
            host_wait_ends <= 0;
        end else if (spi_update || host_rd_valid) begin
            host_wait_ends <= host_wait_ends + 1;
        end
        if (host_cmd_accept) begin
            host_load_cyc <= cyc;
            if (check_wait) begin
                checks++;
                assert (host_wait_ends > 0) else begin
                    $display("ERROR: host command was accepted before any frame ended");
                    errors++;
                end
            end
        end
        if (spi_update && upd_addr != readout_reg) begin
            checks += 2;
            host_wr_seen <= host_wr_seen + 1;
            assert (din_sh == exp_host_word)
                else report_mismatch("host write frame", int'(exp_host_word), int'(din_sh));
            assert (cyc - host_load_cyc == 24)
                else report_mismatch("host write update cycle", 24, cyc - host_load_cyc);
        end
        if (host_rd_valid) begin
            checks += 2;
            assert (host_rd_data == rd_pattern)
                else report_mismatch("host read data", int'(rd_pattern), int'(host_rd_data));
            assert (cyc - host_load_cyc == 40)
                else report_mismatch("host read valid cycle", 40, cyc - host_load_cyc);
        end
        // pixel shows one cycle after its address
        probe_d <= probe;
        exp_pos_d <= exp_pos;
        exp_neg_d <= exp_neg;
        if (probe_d) begin
            checks += 2;
            assert (data_in_pos == exp_pos_d)
                else report_mismatch("frame round trip pos", int'(exp_pos_d), int'(data_in_pos));
            assert (data_in_neg == exp_neg_d)
                else report_mismatch("frame round trip neg", int'(exp_neg_d), int'(data_in_neg));
        end
        drain_d <= class_rd;
        if (drain_d) begin
            checks++;
            assert (class_rd_data == class_ref(drain_idx / class_bytes, drain_idx % class_bytes))
                else report_mismatch("class readout",
                    int'(class_ref(drain_idx / class_bytes, drain_idx % class_bytes)),
                    int'(class_rd_data));
            drain_idx <= drain_idx + 1;
        end else if (!class_rd) begin
            drain_idx <= 0;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic send_host_cmd(input logic rd, input logic [cfg_addr_width-1:0] addr,
                                 input logic [cfg_data_width-1:0] data);
        int n;
        n = 0;
        host_cmd_valid <= 1'b1;
        host_cmd_rd <= rd;
        host_cmd_addr <= addr;
        host_cmd_data <= data;
        @(posedge clk);
        while (!host_cmd_accept && n < 2000) begin
            @(posedge clk);
            n++;
        end
        host_cmd_valid <= 1'b0;
        checks++;
        assert (host_cmd_accept) else begin
            $display("ERROR: host command was never accepted");
            errors++;
        end
    endtask

    task automatic wait_frame_end();
        int n;
        n = 0;
        @(posedge clk);
        while (!(spi_update || host_rd_valid) && n < 100) begin
            @(posedge clk);
            n++;
        end
        checks++;
        assert (spi_update || host_rd_valid) else begin
            $display("ERROR: serial frame did not finish");
            errors++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic run_readout(input int exp_updates);
        int n;
        int base;
        n = 0;
        base = upd_cnt;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!result_ready && n < 3 * n_regions * region_cycles) begin
            @(posedge clk);
            n++;
        end
        checks += 2;
        assert (result_ready) else begin
            $display("ERROR: result_ready never came");
            errors++;
        end
        assert (upd_cnt - base == exp_updates)
            else report_mismatch("update pulse count", exp_updates, upd_cnt - base);
        // drain all regions through the read pointer
        class_rd <= 1'b1;
        repeat (n_entries) @(posedge clk);
        class_rd <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        int a;
        seed = 59033;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        pix_wr = 1'b0;
        pix_pos = 1'b0;
        pix_neg = 1'b0;
        chip_row = '0;
        chip_col = '0;
        host_cmd_valid = 1'b0;
        host_cmd_rd = 1'b0;
        host_cmd_addr = '0;
        host_cmd_data = '0;
        start = 1'b0;
        class_rd = 1'b0;
        probe = 1'b0;
        exp_pos = 1'b0;
        exp_neg = 1'b0;
        check_wait = 1'b0;
        exp_host_word = '0;
        rd_pattern = 16'hc35a;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        // host write, then host read
        exp_host_word <= {16'h3a5c, host_wr_addr};
        send_host_cmd(1'b0, host_wr_addr, 16'h3a5c);
        wait_frame_end();
        send_host_cmd(1'b1, host_rd_addr, 16'hffff);
        wait_frame_end();

        // frame round trip over the first raster pixels
        for (int i = 0; i < n_pixels; i++) begin
            {pos_bits[i], neg_bits[i]} = 2'($random(seed));
            pix_wr <= 1'b1;
            pix_pos <= pos_bits[i];
            pix_neg <= neg_bits[i];
            @(posedge clk);
        end
        pix_wr <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < n_probes; i++) begin
            a = {$random(seed)} % n_pixels;
            chip_row <= row_width'(a / x_length);
            chip_col <= col_width'(a % x_length);
            exp_pos <= pos_bits[a];
            exp_neg <= neg_bits[a];
            probe <= 1'b1;
            @(posedge clk);
        end
        probe <= 1'b0;
        repeat (2) @(posedge clk);

        // three regions, then the same with a host write in the middle
        run_readout(seq_updates);
        exp_host_word <= {16'h5e21, host_wr_addr};
        fork
            run_readout(seq_updates + 1);
            begin
                wait (reads_seen == class_bytes + 5);
                repeat (12) @(posedge clk);
                check_wait <= 1'b1;
                send_host_cmd(1'b0, host_wr_addr, 16'h5e21);
                check_wait <= 1'b0;
            end
        join
        checks++;
        assert (host_wr_seen == 2) else report_mismatch("host write frames", 2, host_wr_seen);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("ERROR: run did not finish in time, %0d errors so far", errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
frame_geom_pkg.sv
chip_cmd_pkg.sv
frame_loader.sv
spi_config_port.sv
spi_cmd_arbiter.sv
class_readout_seq.sv
class_mem.sv
cnn_harness_top.sv
cnn_harness_assert.sv
tb_cnn_harness.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cnn_harness
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
